/* Bender.yml */
package:
  name: dcache

sources:
  - src/cache_geom_pkg.sv
  - src/mem_op_pkg.sv
  - src/access_ctrl.sv
  - src/tag_array.sv
  - src/data_array.sv
  - src/refill_engine.sv
  - src/store_buffer.sv
  - src/l2_arbiter.sv
  - src/dcache_top.sv
  - target: test
    files:
      - bench/l2_model.sv
      - bench/dcache_tb.sv

/* bench/dcache_tb.sv */
// aligned accesses only; the reference memory covers the low 128 KB that the L2 model holds
`timescale 1ns/1ps

module dcache_tb;

  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  localparam int mem_bytes = 131072;
  localparam int timeout_cycles = 1000;

  logic      clk = 1'b0;
  logic      rst;
  logic      req;
  mem_op_e   op;
  word_t     addr;
  lsq_id_t   lsq_id;
  word_t     wdata;
  logic      ready;
  logic      rsp_valid;
  lsq_id_t   rsp_id;
  word_t     rsp_data;
  logic      l2_cyc;
  logic      l2_stb;
  logic      l2_we;
  l2_addr_t  l2_adr;
  byte_sel_t l2_sel;
  dword_t    l2_dat_w;
  dword_t    l2_dat_r;
  logic      l2_ack;
  logic      long_delay;
  int        read_beats;
  int        write_count;

  logic [7:0] ref_mem [mem_bytes];
  // every store in issue order, as L2 should see it
  l2_addr_t   exp_adr [$];
  byte_sel_t  exp_sel [$];
  int         checks = 0;
  int         errors = 0;
  int         timeouts = 0;
  lsq_id_t    next_id = '0;
  mem_op_e    load_ops [5] = '{lb, lh, lw, lbu, lhu};
  mem_op_e    bp_op [6] = '{sw, sh, sb, sw, sb, sh};
  word_t      bp_addr [6] = '{32'h108, 32'h10e, 32'h4003, 32'h4010, 32'h109, 32'h4022};
  word_t      bp_dat [6] = '{32'h11223344, 32'ha5c3, 32'h7e, 32'hdeadbeef, 32'hf0, 32'h1357};

  always #4 clk = ~clk;

  dcache_top dut_i (
    .clk, .rst, .req, .op, .addr, .lsq_id, .wdata,
    .ready, .rsp_valid, .rsp_id, .rsp_data,
    .l2_cyc, .l2_stb, .l2_we, .l2_adr, .l2_sel, .l2_dat_w, .l2_dat_r, .l2_ack
  );

  l2_model l2_i (
    .clk, .rst, .cyc(l2_cyc), .stb(l2_stb), .we(l2_we), .adr(l2_adr), .sel(l2_sel),
    .dat_w(l2_dat_w), .dat_r(l2_dat_r), .ack(l2_ack), .long_delay, .read_beats, .write_count
  );

  function automatic int size_of(mem_op_e o);
    case (o)
      lb, lbu, sb: return 1;
      lh, lhu, sh: return 2;
      default: return 4;
    endcase
  endfunction

  // little-endian bytes at a, then the op's extension rule
  function automatic word_t load_value(mem_op_e o, word_t a);
    word_t v;
    for (int i = 0; i < 4; i++) begin
      v[8*i +: 8] = ref_mem[a[16:0] + i];
    end
    case (o)
      lb: return {{24{v[7]}}, v[7:0]};
      lh: return {{16{v[15]}}, v[15:0]};
      lbu: return {24'h000000, v[7:0]};
      lhu: return {16'h0000, v[15:0]};
      default: return v;
    endcase
  endfunction

  function automatic dword_t ref_dword(word_t a);
    dword_t v;
    for (int b = 0; b < 8; b++) begin
      v[8*b +: 8] = ref_mem[{a[16:3], 3'b000} + b];
    end
    return v;
  endfunction

  task automatic fill_memory();
    dword_t v;
    for (int i = 0; i < mem_bytes / 8; i++) begin
      v[31:0] = i * 32'h9e3779b1;
      v[63:32] = (i ^ 32'h5bd1e995) * 32'h85ebca6b;
      l2_i.mem[i] = v;
      for (int b = 0; b < 8; b++) begin
        ref_mem[i*8 + b] = v[8*b +: 8];
      end
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    timeouts++;
    $display("timeout at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic verify(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("error %0t: %s", $time, what);
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_request(input mem_op_e o, input word_t a, input word_t d);
    int t;
    req = 1'b1;
    op = o;
    addr = a;
    lsq_id = next_id;
    wdata = d;
    t = 0;
    while (!ready && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (!ready) begin
      abort_on_timeout("ready to take a request");
    end
    @(negedge clk);
    req = 1'b0;
    next_id++;
  endtask

  task automatic run_load(input mem_op_e o, input word_t a, input int exp_beats);
    word_t   exp;
    lsq_id_t id;
    int      beats0;
    int      lat;
    exp = load_value(o, a);
    id = next_id;
    beats0 = read_beats;
    issue_request(o, a, '0);
    lat = 0;
    while (!rsp_valid && lat < timeout_cycles) begin
      @(negedge clk);
      lat++;
    end
    if (!rsp_valid) begin
      abort_on_timeout("a load response");
    end
    verify(rsp_id == id, $sformatf("rsp_id %0d, expected %0d", rsp_id, id));
    verify(rsp_data == exp,
           $sformatf("%s at %h returned %h, expected %h", o.name(), a, rsp_data, exp));
    if (exp_beats >= 0) begin
      verify(read_beats - beats0 == exp_beats,
             $sformatf("load at %h took %0d read beats, expected %0d",
                       a, read_beats - beats0, exp_beats));
    end
    // a hit answers two cycles after the accepting edge
    if (exp_beats == 0) begin
      verify(lat == 2, $sformatf("hit at %h answered after %0d cycles", a, lat));
    end
  endtask

  task automatic wait_writes(input int n);
    int t;
    t = 0;
    while (write_count < n && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (write_count < n) begin
      abort_on_timeout("L2 write acknowledges");
    end
  endtask

  task automatic check_l2_word(input word_t a);
    verify(l2_i.mem[a[16:3]] == ref_dword(a),
           $sformatf("L2 doubleword at %h is %h, expected %h",
                     a, l2_i.mem[a[16:3]], ref_dword(a)));
  endtask

  task automatic run_store(input mem_op_e o, input word_t a, input word_t d, input logic wait_ack);
    int n;
    n = size_of(o);
    for (int i = 0; i < n; i++) begin
      ref_mem[a[16:0] + i] = d[8*i +: 8];
    end
    exp_adr.push_back(a[31:3]);
    exp_sel.push_back(byte_sel_t'(((1 << n) - 1) << a[2:0]));
    issue_request(o, a, d);
    if (wait_ack) begin
      wait_writes(exp_adr.size());
      check_l2_word(a);
    end
  endtask

  initial begin
    word_t   a;
    mem_op_e o;
    int      k;
    void'($urandom(18));
    rst = 1'b1;
    req = 1'b0;
    op = lw;
    addr = '0;
    lsq_id = '0;
    wdata = '0;
    long_delay = 1'b0;
    fill_memory();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    verify(ready && !l2_cyc && !l2_stb, "ready low or L2 bus active after reset");

    // first touch of a line fetches 8 beats, later loads hit
    run_load(lw, 32'h100, 8);
    run_load(lw, 32'h104, 0);
    run_load(lb, 32'h101, 0);
    run_load(lh, 32'h102, 0);
    run_load(lbu, 32'h13f, 0);
    run_load(lhu, 32'h13e, 0);

    // store on a cached line
    run_store(sw, 32'h110, 32'h80c0ffee, 1'b1);
    run_load(lw, 32'h110, 0);
    run_load(lb, 32'h113, 0);
    run_load(lhu, 32'h112, 0);

    // uncached line, the miss has to see both stores
    run_store(sh, 32'h4006, 32'h0000beef, 1'b1);
    run_store(sb, 32'h4001, 32'h0000009a, 1'b0);
    run_load(lh, 32'h4006, 8);
    run_load(lbu, 32'h4001, 0);
    run_load(lb, 32'h4001, 0);
    wait_writes(exp_adr.size());
    check_l2_word(32'h4001);

    // mixed random traffic on the cached line
    for (k = 0; k < 24; k++) begin
      o = load_ops[$urandom_range(4, 0)];
      a = 32'h100 + ($urandom_range(63, 0) & ~(size_of(o) - 1));
      if ($urandom_range(3, 0) == 0) begin
        run_store(mem_op_e'({1'b0, o[2:1], 1'b1}), a, $urandom(), 1'b1);
      end else begin
        run_load(o, a, 0);
      end
    end

    // five lines in set 23, the first one is the PLRU victim
    for (k = 0; k < 5; k++) begin
      run_load(lw, 32'h5c0 + k * 32'h2000, 8);
    end
    run_load(lw, 32'h5c0, 8);
    run_load(lw, 32'h5c8, 0);
    run_load(lw, 32'h5c0 + 4 * 32'h2000, 0);

    // slow L2, stores back to back
    long_delay = 1'b1;
    for (k = 0; k < 6; k++) begin
      run_store(bp_op[k], bp_addr[k], bp_dat[k], 1'b0);
    end
    wait_writes(exp_adr.size());
    for (k = 0; k < 6; k++) begin
      check_l2_word(bp_addr[k]);
    end
    for (k = 0; k < 6; k++) begin
      run_load(mem_op_e'({1'b0, bp_op[k][2:1], 1'b0}), bp_addr[k], -1);
    end
    long_delay = 1'b0;

    verify(write_count == exp_adr.size(),
           $sformatf("L2 saw %0d writes, expected %0d", write_count, exp_adr.size()));
    for (k = 0; k < exp_adr.size(); k++) begin
      verify(l2_i.log_adr[k] == exp_adr[k] && l2_i.log_sel[k] == exp_sel[k],
             $sformatf("L2 write %0d went to %h sel %h, expected %h sel %h", k,
                       l2_i.log_adr[k], l2_i.log_sel[k], exp_adr[k], exp_sel[k]));
    end
    finish_run();
  end

endmodule

/* bench/l2_model.sv */
// behavioral Wishbone classic slave; 128 KB of storage, addresses above bit 16 alias, log holds 64 writes
`timescale 1ns/1ps

module l2_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  cache_geom_pkg::l2_addr_t  adr,
  input  cache_geom_pkg::byte_sel_t sel,
  input  cache_geom_pkg::dword_t    dat_w,
  output cache_geom_pkg::dword_t    dat_r,
  output logic                      ack,
  input  logic                      long_delay,
  output int                        read_beats,
  output int                        write_count
);

  import cache_geom_pkg::*;

  localparam int mem_words = 16384;
  localparam int log_depth = 64;

  // contents are loaded by the testbench before reset ends
  dword_t    mem [mem_words];
  l2_addr_t  log_adr [log_depth];
  byte_sel_t log_sel [log_depth];

  logic armed;
  int   wait_cnt;

  always @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      armed <= 1'b0;
      wait_cnt <= 0;
      read_beats <= 0;
      write_count <= 0;
    end else begin
      ack <= 1'b0;
      // skip the ack cycle itself, the master moves on at this edge
      if (cyc && stb && !ack) begin
        if (!armed) begin
          armed <= 1'b1;
          wait_cnt <= $urandom_range(3, 0) + (long_delay ? 8 : 0);
        end else if (wait_cnt == 0) begin
          armed <= 1'b0;
          ack <= 1'b1;
          if (we) begin
            for (int b = 0; b < 8; b++) begin
              if (sel[b]) begin
                mem[adr[13:0]][b*8 +: 8] <= dat_w[b*8 +: 8];
              end
            end
            if (write_count < log_depth) begin
              log_adr[write_count] <= adr;
              log_sel[write_count] <= sel;
            end
            write_count <= write_count + 1;
          end else begin
            dat_r <= mem[adr[13:0]];
            read_beats <= read_beats + 1;
          end
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

/* flist.f */
src/cache_geom_pkg.sv
src/mem_op_pkg.sv
src/access_ctrl.sv
src/tag_array.sv
src/data_array.sv
src/refill_engine.sv
src/store_buffer.sv
src/l2_arbiter.sv
src/dcache_top.sv
bench/l2_model.sv
bench/dcache_tb.sv

/* src/access_ctrl.sv */
// misaligned halfword and word accesses are not checked; one load miss at a time stalls req
`timescale 1ns/1ps

module access_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req,
  input  mem_op_pkg::mem_op_e          op,
  input  mem_op_pkg::word_t            addr,
  input  mem_op_pkg::lsq_id_t          lsq_id,
  input  mem_op_pkg::word_t            wdata,
  output logic                         ready,
  output logic                         rsp_valid,
  output mem_op_pkg::lsq_id_t          rsp_id,
  output mem_op_pkg::word_t            rsp_data,
  output cache_geom_pkg::set_t         lk_set,
  output cache_geom_pkg::tag_t         lk_tag,
  output logic                         lru_touch,
  input  logic                         hit,
  input  cache_geom_pkg::way_t         hit_way,
  output cache_geom_pkg::darray_addr_t rd_idx,
  input  cache_geom_pkg::dword_t       rd_data,
  output logic                         refill_start,
  output logic [25:0]                  refill_line,
  input  logic                         refill_done,
  input  logic                         sb_busy,
  output logic                         sb_push,
  output cache_geom_pkg::l2_addr_t     sb_adr,
  output cache_geom_pkg::byte_sel_t    sb_sel,
  output cache_geom_pkg::dword_t       sb_dat,
  output logic                         st_wen,
  output cache_geom_pkg::darray_addr_t st_idx,
  output cache_geom_pkg::byte_sel_t    st_sel,
  output cache_geom_pkg::dword_t       st_dat
);

  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  typedef enum logic [1:0] {idle, lookup, wait_store, refill} state_e;

  state_e     state;

  // latched request
  mem_op_e    req_op;
  word_t      req_addr;
  lsq_id_t    req_id;
  word_t      req_wdata;

  // load hit waiting on the data-array read
  logic       rd_pend;
  mem_op_e    rd_op;
  logic [2:0] rd_off;
  lsq_id_t    rd_id;

  logic       is_store;
  logic       finish;
  logic       accept;
  logic [3:0] word_sel;
  word_t      word_dat;
  word_t      ld_word;
  word_t      ld_shift;
  word_t      ld_ext;

  assign is_store = req_op[0];
  assign lk_set = req_addr[12:6];
  assign lk_tag = req_addr[31:13];
  assign rd_idx = {lk_set, hit_way, req_addr[5:3]};
  assign st_idx = rd_idx;

  // lookup retires this cycle, so a new request can be taken at the same edge
  assign finish = (state == lookup) && (is_store ? !sb_busy : hit);
  assign ready = (state == idle) || finish;
  assign accept = req && ready;

  assign lru_touch = (state == lookup) && hit;

  // a miss waits for the store buffer so the fetched line holds earlier stores
  assign refill_start = (state == lookup) && !is_store && !hit && !sb_busy;
  assign refill_line = req_addr[31:6];

  // write-through: every store goes to L2, hits also update the line
  assign sb_push = (state == lookup) && is_store && !sb_busy;
  assign st_wen = sb_push && hit;
  assign sb_adr = req_addr[31:3];
  assign sb_sel = st_sel;
  assign sb_dat = st_dat;

  always_comb begin
    case (req_op)
      sb: begin
        word_sel = 4'b0001 << req_addr[1:0];
        word_dat = {4{req_wdata[7:0]}};
      end
      sh: begin
        word_sel = 4'b0011 << {req_addr[1], 1'b0};
        word_dat = {2{req_wdata[15:0]}};
      end
      default: begin
        word_sel = 4'b1111;
        word_dat = req_wdata;
      end
    endcase
  end

  assign st_sel = req_addr[2] ? {word_sel, 4'b0000} : {4'b0000, word_sel};
  assign st_dat = {2{word_dat}};

  // pick the word, align the addressed byte to bit 0, then extend
  assign ld_word = rd_off[2] ? rd_data[63:32] : rd_data[31:0];
  assign ld_shift = ld_word >> {rd_off[1:0], 3'b000};

  always_comb begin
    case (rd_op)
      lb: ld_ext = {{24{ld_shift[7]}}, ld_shift[7:0]};
      lh: ld_ext = {{16{ld_shift[15]}}, ld_shift[15:0]};
      lbu: ld_ext = {24'h000000, ld_shift[7:0]};
      lhu: ld_ext = {16'h0000, ld_shift[15:0]};
      default: ld_ext = ld_shift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            state <= lookup;
          end
        end
        lookup: begin
          if (finish) begin
            state <= accept ? lookup : idle;
          end else begin
            state <= sb_busy ? wait_store : refill;
          end
        end
        wait_store: begin
          if (!sb_busy) begin
            state <= lookup;
          end
        end
        default: begin
          // replay the load, which now hits
          if (refill_done) begin
            state <= lookup;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_op <= op;
      req_addr <= addr;
      req_id <= lsq_id;
      req_wdata <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rd_pend <= finish && !is_store;
      rsp_valid <= rd_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      rd_op <= req_op;
      rd_off <= req_addr[2:0];
      rd_id <= req_id;
    end
    if (rd_pend) begin
      rsp_id <= rd_id;
      rsp_data <= ld_ext;
    end
  end

endmodule

/* src/cache_geom_pkg.sv */
// geometry is fixed at 32 KB, 4 ways and 64-byte lines; the address fields below depend on it
package cache_geom_pkg;

  localparam int num_sets = 128;
  localparam int num_ways = 4;
  localparam int line_bytes = 64;
  // one beat per 64-bit doubleword
  localparam int beats_per_line = line_bytes / 8;

  typedef logic [6:0] set_t;
  // address bits 31 to 13
  typedef logic [18:0] tag_t;
  typedef logic [1:0] way_t;
  typedef logic [2:0] beat_t;
  typedef logic [63:0] dword_t;
  // doubleword address, bits 31 to 3
  typedef logic [28:0] l2_addr_t;
  // {set, way, beat}
  typedef logic [11:0] darray_addr_t;
  typedef logic [7:0] byte_sel_t;
  // tree pseudo-LRU state of one set
  typedef logic [2:0] lru_t;

endpackage

/* src/data_array.sv */
// a read of an index written at the same edge returns the old contents
`timescale 1ns/1ps

module data_array (
  input  logic                         clk,
  input  cache_geom_pkg::darray_addr_t rd_idx,
  input  logic                         wen,
  input  cache_geom_pkg::darray_addr_t wr_idx,
  input  cache_geom_pkg::byte_sel_t    wr_sel,
  input  cache_geom_pkg::dword_t       wr_dat,
  output cache_geom_pkg::dword_t       rd_data
);

  import cache_geom_pkg::*;

  dword_t mem [num_sets * num_ways * beats_per_line];

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int b = 0; b < $bits(byte_sel_t); b++) begin
        if (wr_sel[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_dat[b*8 +: 8];
        end
      end
    end
    rd_data <= mem[rd_idx];
  end

endmodule

/* src/dcache_top.sv */
// 32 KB 4-way write-through data cache, no write-allocate, blocking on a load miss
`timescale 1ns/1ps

module dcache_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req,
  input  mem_op_pkg::mem_op_e       op,
  input  mem_op_pkg::word_t         addr,
  input  mem_op_pkg::lsq_id_t       lsq_id,
  input  mem_op_pkg::word_t         wdata,
  output logic                      ready,
  output logic                      rsp_valid,
  output mem_op_pkg::lsq_id_t       rsp_id,
  output mem_op_pkg::word_t         rsp_data,
  output logic                      l2_cyc,
  output logic                      l2_stb,
  output logic                      l2_we,
  output cache_geom_pkg::l2_addr_t  l2_adr,
  output cache_geom_pkg::byte_sel_t l2_sel,
  output cache_geom_pkg::dword_t    l2_dat_w,
  input  cache_geom_pkg::dword_t    l2_dat_r,
  input  logic                      l2_ack
);

  import cache_geom_pkg::*;

  set_t         lk_set;
  tag_t         lk_tag;
  logic         lru_touch;
  logic         hit;
  way_t         hit_way;
  way_t         victim_way;
  darray_addr_t rd_idx;
  dword_t       rd_data;
  logic         refill_start;
  logic [25:0]  refill_line;
  logic         refill_done;
  logic         sb_busy;
  logic         sb_push;
  l2_addr_t     sb_adr;
  byte_sel_t    sb_sel;
  dword_t       sb_dat;
  logic         st_wen;
  darray_addr_t st_idx;
  byte_sel_t    st_sel;
  dword_t       st_dat;
  logic         fill_wen;
  darray_addr_t fill_idx;
  dword_t       fill_dat;
  logic         fill_valid;
  set_t         fill_set;
  tag_t         fill_tag;

  // data-array write port
  logic         dw_en;
  darray_addr_t dw_idx;
  byte_sel_t    dw_sel;
  dword_t       dw_dat;

  // refill and store masters
  logic         rf_cyc;
  logic         rf_stb;
  logic         rf_ack;
  l2_addr_t     rf_adr;
  dword_t       rf_dat_r;
  logic         sbw_cyc;
  logic         sbw_stb;
  logic         sbw_we;
  logic         sbw_ack;
  l2_addr_t     sbw_adr;
  byte_sel_t    sbw_sel;
  dword_t       sbw_dat;

  // refill beats and store hits never fall in the same cycle
  assign dw_en = fill_wen || st_wen;
  assign dw_idx = fill_wen ? fill_idx : st_idx;
  assign dw_sel = fill_wen ? '1 : st_sel;
  assign dw_dat = fill_wen ? fill_dat : st_dat;

  access_ctrl ac_i (
    .clk, .rst, .req, .op, .addr, .lsq_id, .wdata,
    .ready, .rsp_valid, .rsp_id, .rsp_data,
    .lk_set, .lk_tag, .lru_touch, .hit, .hit_way, .rd_idx, .rd_data,
    .refill_start, .refill_line, .refill_done,
    .sb_busy, .sb_push, .sb_adr, .sb_sel, .sb_dat,
    .st_wen, .st_idx, .st_sel, .st_dat
  );

  // the set stays on lk_set during a refill, so the victim is still the filled way
  tag_array tag_i (
    .clk, .rst, .lk_set, .lk_tag, .lru_touch,
    .fill_valid, .fill_set, .fill_way(victim_way), .fill_tag,
    .hit, .hit_way, .victim_way
  );

  data_array data_i (
    .clk, .rd_idx, .wen(dw_en), .wr_idx(dw_idx), .wr_sel(dw_sel), .wr_dat(dw_dat),
    .rd_data
  );

  refill_engine rf_i (
    .clk, .rst, .start(refill_start), .line(refill_line), .way(victim_way),
    .cyc(rf_cyc), .stb(rf_stb), .adr(rf_adr), .ack(rf_ack), .dat_r(rf_dat_r),
    .done(refill_done), .fill_wen, .fill_idx, .fill_dat,
    .fill_valid, .fill_set, .fill_tag
  );

  store_buffer sb_i (
    .clk, .rst, .push(sb_push), .adr(sb_adr), .sel(sb_sel), .dat(sb_dat),
    .busy(sb_busy), .cyc(sbw_cyc), .stb(sbw_stb), .we(sbw_we),
    .adr_o(sbw_adr), .sel_o(sbw_sel), .dat_o(sbw_dat), .ack(sbw_ack)
  );

  l2_arbiter arb_i (
    .clk, .rst,
    .rf_cyc, .rf_stb, .rf_adr, .rf_ack, .rf_dat_r,
    .sb_cyc(sbw_cyc), .sb_stb(sbw_stb), .sb_we(sbw_we), .sb_adr(sbw_adr),
    .sb_sel(sbw_sel), .sb_dat(sbw_dat), .sb_ack(sbw_ack),
    .l2_cyc, .l2_stb, .l2_we, .l2_adr, .l2_sel, .l2_dat_w, .l2_dat_r, .l2_ack
  );

endmodule

/* src/l2_arbiter.sv */
// refill wins ties; a new owner is granted only in a cycle where the bus cyc is low
`timescale 1ns/1ps

module l2_arbiter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rf_cyc,
  input  logic                      rf_stb,
  input  cache_geom_pkg::l2_addr_t  rf_adr,
  output logic                      rf_ack,
  output cache_geom_pkg::dword_t    rf_dat_r,
  input  logic                      sb_cyc,
  input  logic                      sb_stb,
  input  logic                      sb_we,
  input  cache_geom_pkg::l2_addr_t  sb_adr,
  input  cache_geom_pkg::byte_sel_t sb_sel,
  input  cache_geom_pkg::dword_t    sb_dat,
  output logic                      sb_ack,
  output logic                      l2_cyc,
  output logic                      l2_stb,
  output logic                      l2_we,
  output cache_geom_pkg::l2_addr_t  l2_adr,
  output cache_geom_pkg::byte_sel_t l2_sel,
  output cache_geom_pkg::dword_t    l2_dat_w,
  input  cache_geom_pkg::dword_t    l2_dat_r,
  input  logic                      l2_ack
);

  typedef enum logic [1:0] {own_none, own_refill, own_store} owner_e;

  owner_e owner;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= own_none;
    end else begin
      case (owner)
        own_none: begin
          if (rf_cyc) begin
            owner <= own_refill;
          end else if (sb_cyc) begin
            owner <= own_store;
          end
        end
        own_refill: begin
          if (!rf_cyc) begin
            owner <= own_none;
          end
        end
        default: begin
          if (!sb_cyc) begin
            owner <= own_none;
          end
        end
      endcase
    end
  end

  always_comb begin
    l2_cyc = 1'b0;
    l2_stb = 1'b0;
    l2_we = 1'b0;
    l2_adr = rf_adr;
    l2_sel = '1;
    // only the store side ever writes
    l2_dat_w = sb_dat;
    case (owner)
      own_refill: begin
        l2_cyc = rf_cyc;
        l2_stb = rf_stb;
      end
      own_store: begin
        l2_cyc = sb_cyc;
        l2_stb = sb_stb;
        l2_we = sb_we;
        l2_adr = sb_adr;
        l2_sel = sb_sel;
      end
      default: begin
        l2_cyc = 1'b0;
      end
    endcase
  end

  assign rf_ack = (owner == own_refill) && l2_ack;
  assign sb_ack = (owner == own_store) && l2_ack;
  assign rf_dat_r = l2_dat_r;

endmodule

/* src/mem_op_pkg.sv */
// op codes follow the LSQ encoding; other 4-bit values are treated as lw or sw
package mem_op_pkg;

  // bit 0 is the write flag, bits 3:1 give size and signedness
  typedef enum logic [3:0] {
    lb  = 4'b0000,
    sb  = 4'b0001,
    lh  = 4'b0010,
    sh  = 4'b0011,
    lw  = 4'b0100,
    sw  = 4'b0101,
    lbu = 4'b1000,
    lhu = 4'b1010
  } mem_op_e;

  typedef logic [31:0] word_t;
  typedef logic [3:0] lsq_id_t;

endpackage

/* src/refill_engine.sv */
// one line at a time, beats in address order from beat 0; start is ignored while busy
`timescale 1ns/1ps

module refill_engine (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic [25:0]                  line,
  input  cache_geom_pkg::way_t         way,
  output logic                         cyc,
  output logic                         stb,
  output cache_geom_pkg::l2_addr_t     adr,
  input  logic                         ack,
  input  cache_geom_pkg::dword_t       dat_r,
  output logic                         done,
  output logic                         fill_wen,
  output cache_geom_pkg::darray_addr_t fill_idx,
  output cache_geom_pkg::dword_t       fill_dat,
  output logic                         fill_valid,
  output cache_geom_pkg::set_t         fill_set,
  output cache_geom_pkg::tag_t         fill_tag
);

  import cache_geom_pkg::*;

  logic        active;
  beat_t       beat;
  logic [25:0] line_q;
  way_t        way_q;
  logic        last;

  // cyc stays up across all beats
  assign cyc = active;
  assign stb = active;
  assign adr = {line_q, beat};
  assign last = beat == beat_t'(beats_per_line - 1);

  assign fill_wen = active && ack;
  assign fill_idx = {fill_set, way_q, beat};
  assign fill_dat = dat_r;
  // tag goes in with the last beat
  assign fill_valid = fill_wen && last;
  assign fill_set = line_q[6:0];
  assign fill_tag = line_q[25:7];

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      beat <= '0;
      done <= 1'b0;
    end else begin
      done <= fill_valid;
      if (start && !active) begin
        active <= 1'b1;
        beat <= '0;
      end else if (fill_wen) begin
        beat <= beat + 1'b1;
        if (last) begin
          active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !active) begin
      line_q <= line;
      way_q <= way;
    end
  end

endmodule

/* src/store_buffer.sv */
// single entry; a push while busy would overwrite the pending store
`timescale 1ns/1ps

module store_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  cache_geom_pkg::l2_addr_t  adr,
  input  cache_geom_pkg::byte_sel_t sel,
  input  cache_geom_pkg::dword_t    dat,
  output logic                      busy,
  output logic                      cyc,
  output logic                      stb,
  output logic                      we,
  output cache_geom_pkg::l2_addr_t  adr_o,
  output cache_geom_pkg::byte_sel_t sel_o,
  output cache_geom_pkg::dword_t    dat_o,
  input  logic                      ack
);

  logic full;

  assign busy = full;
  assign cyc = full;
  assign stb = full;
  assign we = full;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (push) begin
      full <= 1'b1;
    end else if (ack) begin
      full <= 1'b0;
    end
  end

  // entry stays stable on the bus until acked
  always_ff @(posedge clk) begin
    if (push) begin
      adr_o <= adr;
      sel_o <= sel;
      dat_o <= dat;
    end
  end

endmodule

/* src/tag_array.sv */
// valid bits and LRU clear on reset; lookup and victim choice are combinational on lk_set
`timescale 1ns/1ps

module tag_array (
  input  logic                 clk,
  input  logic                 rst,
  input  cache_geom_pkg::set_t lk_set,
  input  cache_geom_pkg::tag_t lk_tag,
  input  logic                 lru_touch,
  input  logic                 fill_valid,
  input  cache_geom_pkg::set_t fill_set,
  input  cache_geom_pkg::way_t fill_way,
  input  cache_geom_pkg::tag_t fill_tag,
  output logic                 hit,
  output cache_geom_pkg::way_t hit_way,
  output cache_geom_pkg::way_t victim_way
);

  import cache_geom_pkg::*;

  logic [num_ways-1:0] valid_q [num_sets];
  tag_t                tag_q [num_sets][num_ways];
  lru_t                lru_q [num_sets];

  logic [num_ways-1:0] set_valid;
  lru_t                set_lru;

  // point the tree away from way w
  function automatic lru_t next_lru(way_t w, lru_t cur);
    lru_t nxt;
    nxt = cur;
    nxt[2] = !w[1];
    if (w[1]) begin
      nxt[1] = !w[0];
    end else begin
      nxt[0] = !w[0];
    end
    return nxt;
  endfunction

  assign set_valid = valid_q[lk_set];
  assign set_lru = lru_q[lk_set];

  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (set_valid[w] && tag_q[lk_set][w] == lk_tag) begin
        hit = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  always_comb begin
    if (set_lru[2]) begin
      victim_way = {1'b1, set_lru[1]};
    end else begin
      victim_way = {1'b0, set_lru[0]};
    end
    // the lowest invalid way takes precedence over the tree
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!set_valid[w]) begin
        victim_way = way_t'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        lru_q[s] <= '0;
      end
    end else begin
      if (lru_touch) begin
        lru_q[lk_set] <= next_lru(hit_way, set_lru);
      end
      // installed way becomes most recently used
      if (fill_valid) begin
        valid_q[fill_set][fill_way] <= 1'b1;
        lru_q[fill_set] <= next_lru(fill_way, lru_q[fill_set]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid) begin
      tag_q[fill_set][fill_way] <= fill_tag;
    end
  end

endmodule
